// File: all.f
memPkg.sv
protoPkg.sv
lineBus.sv
physicalMemory.sv
lineArbiter.sv
wordAdaptor.sv
memSubsystem.sv
tbMemSubsystem.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbMemSubsystem -f all.f -o simMemSubsystem \
    && ./obj_dir/simMemSubsystem 2>&1 | tee sim.log \
    || { echo "build or simulation run did not complete"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

// File: tbMemSubsystem.sv
`timescale 1ns/1ns

module tbMemSubsystem import memPkg::*, protoPkg::*; ();

    localparam int latency = 6;
    localparam int depthBits = 6;
    localparam int refIdxBits = depthBits + $clog2(wordsPerLine);
    localparam int respLimit = 4 * latency + 20;
    // room for about 40 word transactions plus reset and drain time
    localparam int txnBudget = 40;
    localparam int watchdogNs = txnBudget * (2 * latency + 8) * 4 + 400;

    logic clk;
    logic rst;
    logic instRead;
    addrT instAddr;
    logic instResp;
    wordT instRdata;
    protoErrT instError;
    logic dataRead;
    logic dataWrite;
    addrT dataAddr;
    wordT dataWdata;
    maskT dataMask;
    logic dataResp;
    wordT dataRdata;
    protoErrT dataError;

    // word view of the line memory with the same depth as the DUT
    wordT refMem [2**refIdxBits] = '{default: '0};
    logic [31:0] seed = 32'd61040;
    int errCount = 0;
    int testCount = 0;
    int failedTests = 0;
    int testStartErr = 0;
    time dataRespT;
    time instRespT;

    // expected rdata per port
    // a clear flag marks a write whose rdata is not checked
    wordT dataExpQ [$];
    bit dataChkQ [$];
    wordT instExpQ [$];

    memSubsystem #(.latency(latency), .depthBits(depthBits)) dut0 (
        .clk(clk), .rst(rst),
        .instRead(instRead), .instAddr(instAddr), .instResp(instResp),
        .instRdata(instRdata), .instError(instError),
        .dataRead(dataRead), .dataWrite(dataWrite), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataMask(dataMask), .dataResp(dataResp),
        .dataRdata(dataRdata), .dataError(dataError)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 16);
    endfunction

    // word aligned and inside the modelled depth
    function automatic addrT randAddr();
        logic [31:0] r;
        r = nextRand();
        return {{(30 - refIdxBits){1'b0}}, r[refIdxBits+1:2], 2'b00};
    endfunction

    function automatic wordT refRead(addrT a);
        return refMem[a[2 +: refIdxBits]];
    endfunction

    function automatic void refMerge(addrT a, wordT d, maskT m);
        wordT w;
        w = refMem[a[2 +: refIdxBits]];
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        refMem[a[2 +: refIdxBits]] = w;
    endfunction

    task automatic checkWord(string name, wordT exp, wordT got);
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkErr(string name, protoErrT exp, protoErrT got);
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
            errCount++;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic got);
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic reportFailure(string msg);
        $display("t=%0t %s", $time, msg);
        errCount++;
    endtask

    // lands 1 ns after the rising edge, where inputs change
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitResp(input bit inst, output int cycles);
        cycles = 0;
        do begin
            nextCycle();
            cycles++;
        end while (!(inst ? instResp : dataResp) && cycles < respLimit);
        if (!(inst ? instResp : dataResp)) begin
            reportFailure($sformatf("no %s within %0d cycles of the request",
                inst ? "instResp" : "dataResp", respLimit));
        end
    endtask

    task automatic waitIdle(input bit inst);
        int n;
        adaptStateT st;
        n = 0;
        st = inst ? dut0.instAdaptor.state : dut0.dataAdaptor.state;
        while (st != idle && n < respLimit) begin
            nextCycle();
            n++;
            st = inst ? dut0.instAdaptor.state : dut0.dataAdaptor.state;
        end
        if (st != idle) begin
            reportFailure($sformatf("%s adaptor never left state %s",
                inst ? "instruction" : "data", st.name()));
        end
    endtask

    task automatic dataAccess(input bit wr, input addrT a, input wordT d, input maskT m,
                              output int cycles);
        dataAddr = a;
        dataWdata = d;
        dataMask = m;
        dataRead = !wr;
        dataWrite = wr;
        dataChkQ.push_back(!wr);
        dataExpQ.push_back(refRead(a));
        if (wr) begin
            refMerge(a, d, m);
        end
        waitResp(1'b0, cycles);
        dataRespT = $time;
        dataRead = 1'b0;
        dataWrite = 1'b0;
        nextCycle();
    endtask

    task automatic instFetch(input addrT a, output int cycles);
        instAddr = a;
        instRead = 1'b1;
        instExpQ.push_back(refRead(a));
        waitResp(1'b1, cycles);
        instRespT = $time;
        instRead = 1'b0;
        nextCycle();
    endtask

    task automatic endTest(string name);
        testCount++;
        if (errCount == testStartErr) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errCount - testStartErr);
        end
        testStartErr = errCount;
    endtask

    // resp outputs are stable at the falling edge
    always @(negedge clk) begin : compareResp
        bit chk;
        wordT expWord;
        if (!rst && dataResp) begin
            if (dataExpQ.size() == 0) begin
                reportFailure("dataResp pulsed with no data request pending");
            end else begin
                chk = dataChkQ.pop_front();
                expWord = dataExpQ.pop_front();
                if (chk) begin
                    checkWord("dataRdata", expWord, dataRdata);
                end
            end
        end
        if (!rst && instResp) begin
            if (instExpQ.size() == 0) begin
                reportFailure("instResp pulsed with no instruction request pending");
            end else begin
                checkWord("instRdata", instExpQ.pop_front(), instRdata);
            end
        end
    end

    initial begin
        #watchdogNs;
        $display("watchdog expired after %0d ns, a test is stuck", watchdogNs);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int cycles;
        int spare;
        addrT a;
        maskT m;
        rst = 1'b1;
        instRead = 1'b0;
        instAddr = '0;
        dataRead = 1'b0;
        dataWrite = 1'b0;
        dataAddr = '0;
        dataWdata = '0;
        dataMask = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        nextCycle();

        checkBit("instResp", 1'b0, instResp);
        checkBit("dataResp", 1'b0, dataResp);
        checkErr("instError", errNone, instError);
        checkErr("dataError", errNone, dataError);
        for (int i = 0; i < 2; i++) begin
            dataAccess(1'b0, randAddr(), '0, '0, cycles);
            if (cycles - 1 != latency + 2) begin
                reportFailure($sformatf("data read answered %0d cycles after request, not %0d",
                    cycles - 1, latency + 2));
            end
        end
        endTest("reset and zero reads");

        // full words first so masked writes show which bytes survive
        // and the neighbour word shows whether the rest of the line survives
        for (int i = 0; i < 4; i++) begin
            a = randAddr();
            dataAccess(1'b1, a ^ 32'd4, nextRand(), 4'hf, cycles);
            dataAccess(1'b1, a, nextRand(), 4'hf, cycles);
            m = maskT'(nextRand() >> 12);
            dataAccess(1'b1, a, nextRand(), m, cycles);
            dataAccess(1'b0, a, '0, '0, cycles);
            dataAccess(1'b0, a ^ 32'd4, '0, '0, cycles);
        end
        endTest("masked writes and reads");

        a = randAddr();
        dataAccess(1'b1, a, nextRand(), 4'hf, cycles);
        instFetch(a, cycles);
        endTest("shared line memory");

        a = randAddr();
        dataAccess(1'b1, a, nextRand(), 4'hf, cycles);
        dataAccess(1'b1, a ^ 32'd8, nextRand(), 4'hf, cycles);
        fork
            dataAccess(1'b0, a ^ 32'd8, '0, '0, cycles);
            instFetch(a, spare);
        join
        if (dataRespT >= instRespT) begin
            reportFailure("instResp came before dataResp on a same-cycle request");
        end
        endTest("contention");

        dataAddr = randAddr();
        dataRead = 1'b1;
        repeat (3) nextCycle();
        dataRead = 1'b0;
        nextCycle();
        checkErr("dataError", errReadDropped, dataError);
        waitIdle(1'b0);
        a = randAddr();
        instAddr = a;
        instRead = 1'b1;
        repeat (2) nextCycle();
        instAddr = a ^ 32'd32;
        nextCycle();
        instRead = 1'b0;
        waitIdle(1'b1);
        checkErr("instError", errAddrChanged, instError);
        checkErr("dataError", errReadDropped, dataError);
        endTest("dropped read and moved address");

        dataRead = 1'b1;
        dataWrite = 1'b1;
        nextCycle();
        dataRead = 1'b0;
        dataWrite = 1'b0;
        waitIdle(1'b0);
        checkErr("dataError", errBothAsserted, dataError);
        a = randAddr();
        dataAccess(1'b1, a, 32'h11223344, 4'hf, cycles);
        // the aborted write must leave the line untouched
        dataAddr = a;
        dataWdata = 32'hcafef00d;
        dataMask = 4'hf;
        dataWrite = 1'b1;
        repeat (2) nextCycle();
        dataWdata = 32'h0badf00d;
        nextCycle();
        dataWrite = 1'b0;
        waitIdle(1'b0);
        checkErr("dataError", errDataChanged, dataError);
        dataAccess(1'b0, a, '0, '0, cycles);
        checkErr("instError", errAddrChanged, instError);
        endTest("both strobes and changed wdata");

        if (dataExpQ.size() != 0 || instExpQ.size() != 0) begin
            reportFailure("some requests never got a response");
        end
        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: memSubsystem.sv
`timescale 1ns/1ns

module memSubsystem import memPkg::*, protoPkg::*; #(
    parameter int latency = 25,
    parameter int depthBits = 10
) (
    input logic clk,
    input logic rst,
    // instruction port, read only
    input logic instRead,
    input addrT instAddr,
    output logic instResp,
    output wordT instRdata,
    output protoErrT instError,
    // data port
    input logic dataRead,
    input logic dataWrite,
    input addrT dataAddr,
    input wordT dataWdata,
    input maskT dataMask,
    output logic dataResp,
    output wordT dataRdata,
    output protoErrT dataError
);

    lineBus instBus ();
    lineBus dataBus ();
    lineBus memBus ();

    // instruction side never writes
    wordAdaptor instAdaptor (
        .clk(clk),
        .rst(rst),
        .read(instRead),
        .write(1'b0),
        .address(instAddr),
        .wdata('0),
        .mask('0),
        .resp(instResp),
        .rdata(instRdata),
        .error(instError),
        .line(instBus.host)
    );

    wordAdaptor dataAdaptor (
        .clk(clk),
        .rst(rst),
        .read(dataRead),
        .write(dataWrite),
        .address(dataAddr),
        .wdata(dataWdata),
        .mask(dataMask),
        .resp(dataResp),
        .rdata(dataRdata),
        .error(dataError),
        .line(dataBus.host)
    );

    lineArbiter arbiter0 (
        .clk(clk),
        .rst(rst),
        .dataHost(dataBus.mem),
        .instHost(instBus.mem),
        .mem(memBus.host)
    );

    physicalMemory #(
        .latency(latency),
        .depthBits(depthBits)
    ) pmem0 (
        .clk(clk),
        .rst(rst),
        .bus(memBus.mem)
    );

endmodule

// File: wordAdaptor.sv
`timescale 1ns/1ns

module wordAdaptor import memPkg::*, protoPkg::*; (
    input logic clk,
    input logic rst,
    input logic read,
    input logic write,
    input addrT address,
    input wordT wdata,
    input maskT mask,
    output logic resp,
    output wordT rdata,
    output protoErrT error,
    lineBus.host line
);

    localparam int wordBits = $bits(wordT);
    localparam int wordIdxBits = $clog2(wordsPerLine);

    adaptStateT state;
    addrT reqAddr;
    wordT reqWdata;
    maskT reqMask;
    logic reqWrite;
    logic rdReq;
    logic wrReq;
    lineT lineBuf;
    logic [wordIdxBits-1:0] wordIdx;
    protoErrT violation;
    logic newReq;

    // puts the enabled bytes of one word into a line
    function automatic lineT mergeWord(lineT old, wordT data, maskT m,
                                       logic [wordIdxBits-1:0] idx);
        lineT merged;
        merged = old;
        for (int b = 0; b < $bits(maskT); b++) begin
            if (m[b]) begin
                merged[int'(idx)*wordBits + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign wordIdx = reqAddr[2 +: wordIdxBits];
    assign newReq = (state == idle) && (read || write);

    // line requests always go out line aligned
    assign line.read = rdReq;
    assign line.write = wrReq;
    assign line.address = {reqAddr[$bits(addrT)-1:lineOffsetBits], {lineOffsetBits{1'b0}}};
    assign line.wdata = lineBuf;

    // host signals against the request latched at the start
    always_comb begin
        violation = errNone;
        if (read && write) begin
            violation = errBothAsserted;
        end else if (reqWrite && !write) begin
            violation = errWriteDropped;
        end else if (!reqWrite && !read) begin
            violation = errReadDropped;
        end else if (address != reqAddr) begin
            violation = errAddrChanged;
        end else if (reqWrite && (wdata != reqWdata || mask != reqMask)) begin
            violation = errDataChanged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            reqWrite <= 1'b0;
            rdReq <= 1'b0;
            wrReq <= 1'b0;
            resp <= 1'b0;
            error <= errNone;
        end else begin
            resp <= 1'b0;
            // a line strobe drops right after its resp, in any state
            if (line.resp) begin
                rdReq <= 1'b0;
                wrReq <= 1'b0;
            end
            case (state)
                idle: begin
                    if (read && write) begin
                        error <= errBothAsserted;
                        state <= drain;
                    end else if (read || write) begin
                        reqWrite <= write;
                        rdReq <= 1'b1;
                        state <= lineRead;
                    end
                end
                lineRead, lineWrite: begin
                    // the newest violation overwrites an older code
                    if (violation != errNone) begin
                        error <= violation;
                        state <= drain;
                    end else if (line.resp) begin
                        if (state == lineRead && reqWrite) begin
                            wrReq <= 1'b1;
                            state <= lineWrite;
                        end else begin
                            resp <= 1'b1;
                            state <= respond;
                        end
                    end
                end
                respond: state <= idle;
                drain: begin
                    if (!rdReq && !wrReq && !read && !write) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // note that a violation seen once the line write is out cannot stop that write
    always_ff @(posedge clk) begin
        if (newReq) begin
            reqAddr <= address;
            reqWdata <= wdata;
            reqMask <= mask;
        end
        if (state == lineRead && line.resp) begin
            rdata <= line.rdata[int'(wordIdx)*wordBits +: wordBits];
            lineBuf <= mergeWord(line.rdata, reqWdata, reqMask, wordIdx);
        end
    end

endmodule

// File: lineArbiter.sv
`timescale 1ns/1ns

module lineArbiter (
    input logic clk,
    input logic rst,
    lineBus.mem dataHost,
    lineBus.mem instHost,
    lineBus.host mem
);

    logic locked;
    logic grantData;
    logic dataReq;
    logic instReq;
    logic selData;

    assign dataReq = dataHost.read || dataHost.write;
    assign instReq = instHost.read || instHost.write;

    // data wins a fresh grant, a locked grant stays with its owner
    assign selData = locked ? grantData : dataReq;

    assign mem.read = selData ? dataHost.read : instHost.read;
    assign mem.write = selData ? dataHost.write : instHost.write;
    assign mem.address = selData ? dataHost.address : instHost.address;
    assign mem.wdata = selData ? dataHost.wdata : instHost.wdata;

    // resp only reaches the owner; rdata can go to both
    assign dataHost.resp = mem.resp && selData;
    assign instHost.resp = mem.resp && !selData;
    assign dataHost.rdata = mem.rdata;
    assign instHost.rdata = mem.rdata;

    // lock on the first edge a request passes through, so the owner
    // cannot change while the memory is still working on it
    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            grantData <= 1'b0;
        end else if (locked) begin
            if (mem.resp) begin
                locked <= 1'b0;
            end
        end else if (dataReq || instReq) begin
            locked <= 1'b1;
            grantData <= dataReq;
        end
    end

endmodule

// File: physicalMemory.sv
`timescale 1ns/1ns

module physicalMemory import memPkg::*; #(
    parameter int latency = 25,
    parameter int depthBits = 10
) (
    input logic clk,
    input logic rst,
    lineBus.mem bus
);

    localparam int cntBits = $clog2(latency + 1);

    typedef enum logic [1:0] {
        memIdle,
        memBusy,
        memRespond,
        memCool
    } memStateT;

    memStateT state;
    logic [cntBits-1:0] count;
    logic [depthBits-1:0] lineIdx;
    logic isWrite;
    logic accept;

    // starts out all zero, upper address bits wrap onto this depth
    lineT store [2**depthBits] = '{default: '0};

    assign accept = (state == memIdle) && (bus.read || bus.write);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memIdle;
            count <= '0;
            bus.resp <= 1'b0;
        end else begin
            bus.resp <= 1'b0;
            case (state)
                memIdle: begin
                    if (accept) begin
                        state <= memBusy;
                        count <= cntBits'(latency - 1);
                    end
                end
                memBusy: begin
                    if (count == '0) begin
                        state <= memRespond;
                        bus.resp <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                // host still holds its request during the resp cycle
                memRespond: state <= memCool;
                // one spare cycle before the next request can be taken
                default: state <= memIdle;
            endcase
        end
    end

    // request details are captured once, the storage is touched at resp
    always_ff @(posedge clk) begin
        if (accept) begin
            lineIdx <= bus.address[lineOffsetBits +: depthBits];
            isWrite <= bus.write;
        end
        if (state == memBusy && count == '0) begin
            if (isWrite) begin
                store[lineIdx] <= bus.wdata;
            end else begin
                bus.rdata <= store[lineIdx];
            end
        end
    end

endmodule

// File: lineBus.sv
`timescale 1ns/1ns

interface lineBus import memPkg::*; ();

    // request side, held steady by the host until it samples resp
    logic read;
    logic write;
    addrT address;
    lineT wdata;

    // one-cycle response pulse, rdata valid alongside it
    logic resp;
    lineT rdata;

    modport host (
        output read,
        output write,
        output address,
        output wdata,
        input resp,
        input rdata
    );

    modport mem (
        input read,
        input write,
        input address,
        input wdata,
        output resp,
        output rdata
    );

endinterface

// File: protoPkg.sv
package protoPkg;

    // error codes reported per word port, errNone while the host behaves
    typedef enum logic [2:0] {
        errNone,
        errReadDropped,
        errWriteDropped,
        errAddrChanged,
        errBothAsserted,
        errDataChanged
    } protoErrT;

    // word adaptor FSM
    typedef enum logic [2:0] {
        idle,
        lineRead,
        lineWrite,
        respond,
        // finishing a line transaction after a host violation
        drain
    } adaptStateT;

endpackage

// File: memPkg.sv
package memPkg;

    // byte address as seen by both word ports and the line bus
    typedef logic [31:0] addrT;

    // one host word and its byte enables
    typedef logic [31:0] wordT;
    typedef logic [3:0] maskT;

    // line geometry
    localparam int lineOffsetBits = 5;
    localparam int wordsPerLine = 8;

    // a full line is wordsPerLine words, lowest word at the lowest address
    typedef logic [wordsPerLine*$bits(wordT)-1:0] lineT;

endpackage
